/* files.f */
vex_pkg.sv
vex_ctrl_if.sv
vex_decode.sv
vex_lane_alu.sv
vex_execute.sv
vex_addr_gen.sv
vex_result.sv
vex_execute_stage.sv
tb_vex_execute_stage.sv

/* run.sh */
#!/bin/sh
# build the execute stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_vex_execute_stage -f files.f -o sim_tb
out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1

/* tb_vex_execute_stage.sv */
/*
 * testbench for the two-lane vector execute stage
 * directed and random ALU, reduction and load/store words with stall and flush,
 * compared one cycle later against a reference model
 */
`default_nettype none

module tb_vex_execute_stage;
  import vex_pkg::*;

  typedef struct packed {
    logic  valid_out;
    logic  load_ena;
    logic  store_ena;
    logic  skip_data;
    word_t result0;
    word_t result1;
    word_t addr0;
    word_t addr1;
  } exp_t;

  logic     CLK;
  logic     nRST;
  logic     valid;
  logic     stall;
  logic     flush;
  op_word_u op_word;
  word_t    xs1;
  word_t    xs2;
  word_t    imm;
  word_t    vs1_lane0;
  word_t    vs1_lane1;
  word_t    vs2_lane0;
  word_t    vs2_lane1;
  logic     valid_out;
  logic     load_ena;
  logic     store_ena;
  word_t    result0;
  word_t    result1;
  word_t    addr0;
  word_t    addr1;

  exp_t        expected = '0;
  logic [15:0] lfsr = 16'd7;
  int          err_result = 0;
  int          err_addr = 0;
  int          err_flag = 0;
  int          checks = 0;

  vex_execute_stage i_vex_execute_stage (
    .CLK(CLK), .nRST(nRST), .valid(valid), .stall(stall), .flush(flush),
    .op_word(op_word), .xs1(xs1), .xs2(xs2), .imm(imm),
    .vs1_lane0(vs1_lane0), .vs1_lane1(vs1_lane1),
    .vs2_lane0(vs2_lane0), .vs2_lane1(vs2_lane1),
    .valid_out(valid_out), .load_ena(load_ena), .store_ena(store_ena),
    .result0(result0), .result1(result1), .addr0(addr0), .addr1(addr1)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic word_t rand_bits(input int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // sign-extend the element, then compare as 32-bit
  function automatic logic less_signed(input word_t a, input word_t b, input sew_t sew);
    word_t sa;
    word_t sb;
    case (sew)
      SEW8: begin
        sa = {{24{a[7]}}, a[7:0]};
        sb = {{24{b[7]}}, b[7:0]};
      end
      SEW16: begin
        sa = {{16{a[15]}}, a[15:0]};
        sb = {{16{b[15]}}, b[15:0]};
      end
      default: begin
        sa = a;
        sb = b;
      end
    endcase
    return $signed(sa) < $signed(sb);
  endfunction

  function automatic word_t alu_ref(input word_t a, input word_t b, input aluop_t op,
                                    input sew_t sew);
    case (op)
      ALU_ADD:  return a + b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_MIN:  return less_signed(a, b, sew) ? a : b;
      ALU_MINU: return (a < b) ? a : b;
      ALU_MAX:  return less_signed(a, b, sew) ? b : a;
      default:  return (a < b) ? b : a;
    endcase
  endfunction

  // expected latch contents for one cycle of inputs
  function automatic exp_t ref_model(input op_word_u w, input logic v, input word_t x1,
                                     input word_t x2, input word_t im, input word_t v10,
                                     input word_t v11, input word_t v20, input word_t v21);
    exp_t  e;
    word_t b0;
    word_t b1;
    word_t eew;
    word_t base;
    word_t stride;
    logic  legal;
    e = '0;
    legal = 1'b0;
    case (w.arith.fu_kind)
      FU_ALU: begin
        legal = (w.arith.rs1_sel != RS1_RSVD) && (w.arith.sew != SEW_RSVD);
        b0 = (w.arith.rs1_sel == RS1_I) ? im : ((w.arith.rs1_sel == RS1_X) ? x1 : v10);
        b1 = (w.arith.rs1_sel == RS1_I) ? im : ((w.arith.rs1_sel == RS1_X) ? x1 : v11);
        e.result0 = alu_ref(v20, b0, w.arith.aluop, w.arith.sew);
        e.result1 = alu_ref(v21, b1, w.arith.aluop, w.arith.sew);
        if (w.arith.reduce) begin
          e.result0 = alu_ref(e.result0, e.result1, w.arith.aluop, w.arith.sew);
        end
      end
      FU_LOAD, FU_STORE: begin
        legal = (w.mem.ls_width != WIDTH_RSVD) &&
                !(w.mem.ls_mode == LS_SEGMENT && w.mem.nf_count > w.mem.nf);
        case (w.mem.ls_width)
          WIDTH8:  eew = 32'd1;
          WIDTH16: eew = 32'd2;
          default: eew = 32'd4;
        endcase
        base = w.mem.fullreg ? x1 : x1 + word_t'(w.mem.nf_count) * eew;
        case (w.mem.ls_mode)
          LS_UNIT:    stride = 32'd4;
          LS_STRIDED: stride = x2;
          LS_SEGMENT: stride = (word_t'(w.mem.nf) + 32'd1) * eew;
          default:    stride = '0;
        endcase
        if (w.mem.ls_mode == LS_INDEXED) begin
          e.addr0 = base + v20 * eew;
          e.addr1 = base + v21 * eew;
        end else begin
          e.addr0 = base;
          e.addr1 = base + stride;
        end
      end
      default: ;
    endcase
    e.valid_out = v && legal;
    e.load_ena  = e.valid_out && (w.mem.fu_kind == FU_LOAD);
    e.store_ena = e.valid_out && (w.mem.fu_kind == FU_STORE);
    // data of illegal words is left open
    e.skip_data = !legal;
    return e;
  endfunction

  task automatic check_result(input word_t got, input word_t want, input string name);
    if (got !== want) begin
      err_result++;
      $display("FAILED %0t: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_addr(input word_t got, input word_t want, input string name);
    if (got !== want) begin
      err_addr++;
      $display("FAILED %0t: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string name);
    if (got !== want) begin
      err_flag++;
      $display("FAILED %0t: %s is %b, expected %b", $time, name, got, want);
    end
  endtask

  // reference latch, same edge as the DUT
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      expected <= '0;
    end else if (flush) begin
      expected <= '0;
    end else if (!stall) begin
      expected <= ref_model(op_word, valid, xs1, xs2, imm,
                            vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1);
    end
  end

  // outputs are settled at the falling edge
  always @(negedge CLK) begin
    checks = checks + 1;
    check_flag(valid_out, expected.valid_out, "valid_out");
    check_flag(load_ena, expected.load_ena, "load_ena");
    check_flag(store_ena, expected.store_ena, "store_ena");
    if (!expected.skip_data) begin
      check_result(result0, expected.result0, "result0");
      check_result(result1, expected.result1, "result1");
      check_addr(addr0, expected.addr0, "addr0");
      check_addr(addr1, expected.addr1, "addr1");
    end
  end

  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic set_data();
    xs1       = rand_bits(32);
    xs2       = rand_bits(32);
    imm       = rand_bits(32);
    vs1_lane0 = rand_bits(32);
    vs1_lane1 = rand_bits(32);
    vs2_lane0 = rand_bits(32);
    vs2_lane1 = rand_bits(32);
  endtask

  task automatic drive_alu(input aluop_t op, input rs1_sel_t sel, input sew_t sew,
                           input logic red);
    next_cycle();
    op_word               = '0;
    op_word.arith.fu_kind = FU_ALU;
    op_word.arith.aluop   = op;
    op_word.arith.rs1_sel = sel;
    op_word.arith.sew     = sew;
    op_word.arith.reduce  = red;
    valid = 1'b1;
    stall = 1'b0;
    flush = 1'b0;
    set_data();
  endtask

  task automatic drive_mem(input fu_kind_t kind, input ls_mode_t mode, input ls_width_t width,
                           input nf_t nf, input nf_t cnt, input logic full);
    next_cycle();
    op_word              = '0;
    op_word.mem.fu_kind  = kind;
    op_word.mem.ls_width = width;
    op_word.mem.ls_mode  = mode;
    op_word.mem.nf       = nf;
    op_word.mem.nf_count = cnt;
    op_word.mem.fullreg  = full;
    valid = 1'b1;
    stall = 1'b0;
    flush = 1'b0;
    set_data();
  endtask

  task automatic wait_checks(input int target, input int limit);
    int n;
    n = 0;
    while (checks < target && n < limit) begin
      @(posedge CLK);
      n++;
    end
    if (checks < target) begin
      $display("timeout: output comparison stopped advancing");
      $display("test failed");
      $finish;
    end
  endtask

  initial begin
    word_t r;
    nf_t   nf;
    nf_t   cnt;
    nf_t   tmp;
    int    start;
    nRST = 1'b0;
    valid = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    op_word = '0;
    xs1 = '0;
    xs2 = '0;
    imm = '0;
    vs1_lane0 = '0;
    vs1_lane1 = '0;
    vs2_lane0 = '0;
    vs2_lane1 = '0;
    repeat (3) @(posedge CLK);
    #2 nRST = 1'b1;
    // idle after reset
    repeat (2) next_cycle();

    // every aluop, operand source and element width
    for (int op = 0; op < 8; op++) begin
      for (int sel = 0; sel < 3; sel++) begin
        for (int sew = 0; sew < 3; sew++) begin
          drive_alu(aluop_t'(op[2:0]), rs1_sel_t'(sel[1:0]), sew_t'(sew[1:0]), 1'b0);
        end
      end
    end
    // reductions
    for (int op = 0; op < 8; op++) begin
      for (int sew = 0; sew < 3; sew++) begin
        drive_alu(aluop_t'(op[2:0]), RS1_V, sew_t'(sew[1:0]), 1'b1);
      end
    end
    // random words with bubbles, stalls and flushes mixed in
    for (int i = 0; i < 200; i++) begin
      r = rand_bits(8);
      drive_alu(aluop_t'(r[2:0]), rs1_sel_t'(r[4:3] % 2'd3), sew_t'(r[6:5] % 2'd3), r[7]);
      r = rand_bits(10);
      valid = r[2:0] != 3'd0;
      stall = r[5:3] == 3'd0;
      flush = r[9:6] == 4'd0;
    end

    // loads and stores in every mode
    for (int m = 0; m < 4; m++) begin
      for (int k = 1; k < 3; k++) begin
        for (int i = 0; i < 12; i++) begin
          r = rand_bits(9);
          nf = r[2:0];
          cnt = r[5:3];
          if (m == 2 && cnt > nf) begin
            tmp = nf;
            nf = cnt;
            cnt = tmp;
          end
          drive_mem(fu_kind_t'(k[1:0]), ls_mode_t'(m[1:0]), ls_width_t'(r[7:6] % 2'd3),
                    nf, cnt, r[8]);
        end
      end
    end

    // hold under stall while the inputs move
    drive_alu(ALU_ADD, RS1_X, SEW32, 1'b0);
    repeat (3) begin
      drive_alu(ALU_XOR, RS1_V, SEW8, 1'b0);
      stall = 1'b1;
    end
    // flush overrides stall
    drive_mem(FU_LOAD, LS_UNIT, WIDTH32, 3'd0, 3'd0, 1'b0);
    stall = 1'b1;
    flush = 1'b1;
    drive_alu(ALU_OR, RS1_I, SEW16, 1'b0);
    stall = 1'b1;
    drive_mem(FU_STORE, LS_STRIDED, WIDTH16, 3'd0, 3'd0, 1'b0);
    flush = 1'b1;

    // illegal encodings
    drive_alu(ALU_ADD, RS1_V, SEW8, 1'b0);
    op_word.arith.fu_kind = FU_NONE;
    drive_alu(ALU_ADD, RS1_V, SEW_RSVD, 1'b0);
    drive_alu(ALU_MAX, RS1_RSVD, SEW8, 1'b0);
    drive_mem(FU_LOAD, LS_UNIT, WIDTH_RSVD, 3'd0, 3'd0, 1'b0);
    drive_mem(FU_STORE, LS_SEGMENT, WIDTH8, 3'd2, 3'd5, 1'b0);
    drive_mem(FU_LOAD, LS_INDEXED, WIDTH16, 3'd1, 3'd1, 1'b0);

    next_cycle();
    valid = 1'b0;
    start = checks;
    wait_checks(start + 2, 20);

    $display("errors: results %0d, addresses %0d, flags %0d", err_result, err_addr, err_flag);
    if (err_result + err_addr + err_flag == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vex_execute_stage.sv */
/*
 * two-lane vector execute stage
 * decode, lane ALUs, address generation and result latch
 */
`default_nettype none

module vex_execute_stage (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              valid,
  input  logic              stall,
  input  logic              flush,
  input  vex_pkg::op_word_u op_word,
  input  vex_pkg::word_t    xs1,
  input  vex_pkg::word_t    xs2,
  input  vex_pkg::word_t    imm,
  input  vex_pkg::word_t    vs1_lane0,
  input  vex_pkg::word_t    vs1_lane1,
  input  vex_pkg::word_t    vs2_lane0,
  input  vex_pkg::word_t    vs2_lane1,
  output logic              valid_out,
  output logic              load_ena,
  output logic              store_ena,
  output vex_pkg::word_t    result0,
  output vex_pkg::word_t    result1,
  output vex_pkg::word_t    addr0,
  output vex_pkg::word_t    addr1
);
  import vex_pkg::*;

  word_t lane0_y;
  word_t lane1_y;
  word_t addr0_c;
  word_t addr1_c;

  vex_ctrl_if ctrl_if ();

  vex_decode i_decode (.op_word(op_word), .ctrl(ctrl_if));

  vex_execute i_execute (
    .ctrl(ctrl_if), .xs1(xs1), .imm(imm),
    .vs1_lane0(vs1_lane0), .vs1_lane1(vs1_lane1),
    .vs2_lane0(vs2_lane0), .vs2_lane1(vs2_lane1),
    .lane0_y(lane0_y), .lane1_y(lane1_y)
  );

  vex_addr_gen i_addr_gen (
    .ctrl(ctrl_if), .xs1(xs1), .xs2(xs2),
    .vs2_lane0(vs2_lane0), .vs2_lane1(vs2_lane1),
    .addr0(addr0_c), .addr1(addr1_c)
  );

  vex_result i_result (
    .CLK(CLK), .nRST(nRST), .valid(valid), .stall(stall), .flush(flush),
    .ctrl(ctrl_if), .lane0_y(lane0_y), .lane1_y(lane1_y),
    .addr0_in(addr0_c), .addr1_in(addr1_c),
    .valid_out(valid_out), .load_ena(load_ena), .store_ena(store_ena),
    .result0(result0), .result1(result1), .addr0(addr0), .addr1(addr1)
  );

endmodule

`default_nettype wire

/* vex_result.sv */
/*
 * result stage
 * cross-lane reduction and the output latch with stall and flush
 */
`default_nettype none

module vex_result (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              valid,
  input  logic              stall,
  input  logic              flush,
  vex_ctrl_if.result        ctrl,
  input  vex_pkg::word_t    lane0_y,
  input  vex_pkg::word_t    lane1_y,
  input  vex_pkg::word_t    addr0_in,
  input  vex_pkg::word_t    addr1_in,
  output logic              valid_out,
  output logic              load_ena,
  output logic              store_ena,
  output vex_pkg::word_t    result0,
  output vex_pkg::word_t    result1,
  output vex_pkg::word_t    addr0,
  output vex_pkg::word_t    addr1
);
  import vex_pkg::*;

  word_t red_y;
  logic  red_lt_s;
  logic  red_lt_u;
  logic  is_alu;
  logic  is_mem;
  logic  valid_next;

  assign red_lt_s = elem_lt(lane0_y, lane1_y, ctrl.sew);
  assign red_lt_u = lane0_y < lane1_y;

  always_comb begin
    case (ctrl.aluop)
      ALU_ADD:  red_y = lane0_y + lane1_y;
      ALU_AND:  red_y = lane0_y & lane1_y;
      ALU_OR:   red_y = lane0_y | lane1_y;
      ALU_XOR:  red_y = lane0_y ^ lane1_y;
      ALU_MIN:  red_y = red_lt_s ? lane0_y : lane1_y;
      ALU_MINU: red_y = red_lt_u ? lane0_y : lane1_y;
      ALU_MAX:  red_y = red_lt_s ? lane1_y : lane0_y;
      ALU_MAXU: red_y = red_lt_u ? lane1_y : lane0_y;
      default:  red_y = '0;
    endcase
  end

  assign is_alu     = ctrl.fu_kind == FU_ALU;
  assign is_mem     = (ctrl.fu_kind == FU_LOAD) || (ctrl.fu_kind == FU_STORE);
  assign valid_next = valid && ctrl.legal;

  // flush wins over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_out <= 1'b0;
      load_ena  <= 1'b0;
      store_ena <= 1'b0;
      result0   <= '0;
      result1   <= '0;
      addr0     <= '0;
      addr1     <= '0;
    end else if (flush) begin
      valid_out <= 1'b0;
      load_ena  <= 1'b0;
      store_ena <= 1'b0;
      result0   <= '0;
      result1   <= '0;
      addr0     <= '0;
      addr1     <= '0;
    end else if (!stall) begin
      valid_out <= valid_next;
      load_ena  <= valid_next && ctrl.fu_kind == FU_LOAD;
      store_ena <= valid_next && ctrl.fu_kind == FU_STORE;
      result0   <= is_alu ? (ctrl.reduce ? red_y : lane0_y) : '0;
      result1   <= is_alu ? lane1_y : '0;
      addr0     <= is_mem ? addr0_in : '0;
      addr1     <= is_mem ? addr1_in : '0;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST) flush |=> !valid_out)
    else $error("valid_out set the cycle after flush");

endmodule

`default_nettype wire

/* vex_addr_gen.sv */
/*
 * load/store address generation
 * unit, strided, segment and indexed addresses for both lanes
 */
`default_nettype none

module vex_addr_gen (
  vex_ctrl_if.execute    ctrl,
  input  vex_pkg::word_t xs1,
  input  vex_pkg::word_t xs2,
  input  vex_pkg::word_t vs2_lane0,
  input  vex_pkg::word_t vs2_lane1,
  output vex_pkg::word_t addr0,
  output vex_pkg::word_t addr1
);
  import vex_pkg::*;

  word_t      base;
  word_t      stride;
  logic [1:0] idx_shamt;

  // whole-register access skips the field offset
  assign base = ctrl.fullreg ? xs1 : xs1 + word_t'(ctrl.nf_count) * word_t'(ctrl.eew_bytes);

  always_comb begin
    case (ctrl.ls_mode)
      LS_STRIDED: stride = xs2;
      LS_SEGMENT: stride = (word_t'(ctrl.nf) + 1) * word_t'(ctrl.eew_bytes);
      default:    stride = UNIT_STRIDE_BYTES;
    endcase
  end

  // byte count to shift amount
  assign idx_shamt = ctrl.eew_bytes[2] ? 2'd2 : (ctrl.eew_bytes[1] ? 2'd1 : 2'd0);

  assign addr0 = (ctrl.ls_mode == LS_INDEXED) ? base + (vs2_lane0 << idx_shamt) : base;
  assign addr1 = (ctrl.ls_mode == LS_INDEXED) ? base + (vs2_lane1 << idx_shamt) : base + stride;

  always_comb begin
    if (ctrl.legal && ctrl.ls_mode == LS_SEGMENT) begin
      assert (ctrl.nf_count <= ctrl.nf)
        else $error("segment field number past nf");
    end
  end

endmodule

`default_nettype wire

/* vex_execute.sv */
/*
 * element-wise execute
 * scalar operand select feeding the two lane ALUs
 */
`default_nettype none

module vex_execute (
  vex_ctrl_if.execute    ctrl,
  input  vex_pkg::word_t xs1,
  input  vex_pkg::word_t imm,
  input  vex_pkg::word_t vs1_lane0,
  input  vex_pkg::word_t vs1_lane1,
  input  vex_pkg::word_t vs2_lane0,
  input  vex_pkg::word_t vs2_lane1,
  output vex_pkg::word_t lane0_y,
  output vex_pkg::word_t lane1_y
);
  import vex_pkg::*;

  word_t b0;
  word_t b1;

  always_comb begin
    case (ctrl.rs1_sel)
      RS1_V: begin
        b0 = vs1_lane0;
        b1 = vs1_lane1;
      end
      RS1_I: begin
        b0 = imm;
        b1 = imm;
      end
      RS1_X: begin
        b0 = xs1;
        b1 = xs1;
      end
      default: begin
        b0 = '0;
        b1 = '0;
      end
    endcase
  end

  vex_lane_alu i_lane0 (.a(vs2_lane0), .b(b0), .aluop(ctrl.aluop), .sew(ctrl.sew), .y(lane0_y));
  vex_lane_alu i_lane1 (.a(vs2_lane1), .b(b1), .aluop(ctrl.aluop), .sew(ctrl.sew), .y(lane1_y));

endmodule

`default_nettype wire

/* vex_lane_alu.sv */
/*
 * lane ALU
 * 32-bit add/logic and min/max, signed compare at element width
 */
`default_nettype none

module vex_lane_alu (
  input  vex_pkg::word_t  a,
  input  vex_pkg::word_t  b,
  input  vex_pkg::aluop_t aluop,
  input  vex_pkg::sew_t   sew,
  output vex_pkg::word_t  y
);
  import vex_pkg::*;

  logic lt_s;
  logic lt_u;

  // a is the vector source, b the selected operand
  assign lt_s = elem_lt(a, b, sew);
  assign lt_u = a < b;

  always_comb begin
    case (aluop)
      ALU_ADD:  y = a + b;
      ALU_AND:  y = a & b;
      ALU_OR:   y = a | b;
      ALU_XOR:  y = a ^ b;
      ALU_MIN:  y = lt_s ? a : b;
      ALU_MINU: y = lt_u ? a : b;
      ALU_MAX:  y = lt_s ? b : a;
      ALU_MAXU: y = lt_u ? b : a;
      default:  y = '0;
    endcase
  end

endmodule

`default_nettype wire

/* vex_decode.sv */
/*
 * instruction decode
 * reads the op word as arithmetic or memory form and flags illegal codes
 */
`default_nettype none

module vex_decode (
  input  vex_pkg::op_word_u op_word,
  vex_ctrl_if.decode        ctrl
);
  import vex_pkg::*;

  always_comb begin
    ctrl.fu_kind   = op_word.arith.fu_kind;
    ctrl.aluop     = ALU_ADD;
    ctrl.rs1_sel   = RS1_V;
    ctrl.sew       = SEW8;
    ctrl.reduce    = 1'b0;
    ctrl.eew_bytes = 3'd0;
    ctrl.ls_mode   = LS_UNIT;
    ctrl.nf        = '0;
    ctrl.nf_count  = '0;
    ctrl.fullreg   = 1'b0;
    ctrl.legal     = 1'b0;
    case (op_word.arith.fu_kind)
      FU_ALU: begin
        ctrl.aluop   = op_word.arith.aluop;
        ctrl.rs1_sel = op_word.arith.rs1_sel;
        ctrl.sew     = op_word.arith.sew;
        ctrl.reduce  = op_word.arith.reduce;
        ctrl.legal   = (op_word.arith.rs1_sel != RS1_RSVD) && (op_word.arith.sew != SEW_RSVD);
      end
      FU_LOAD, FU_STORE: begin
        ctrl.ls_mode  = op_word.mem.ls_mode;
        ctrl.nf       = op_word.mem.nf;
        ctrl.nf_count = op_word.mem.nf_count;
        ctrl.fullreg  = op_word.mem.fullreg;
        case (op_word.mem.ls_width)
          WIDTH8:  ctrl.eew_bytes = 3'd1;
          WIDTH16: ctrl.eew_bytes = 3'd2;
          WIDTH32: ctrl.eew_bytes = 3'd4;
          default: ctrl.eew_bytes = 3'd0;
        endcase
        // segment field past the last one
        ctrl.legal = (op_word.mem.ls_width != WIDTH_RSVD) &&
                     !(op_word.mem.ls_mode == LS_SEGMENT &&
                       op_word.mem.nf_count > op_word.mem.nf);
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* vex_ctrl_if.sv */
/*
 * decoded control bundle
 * levels from decode, read by execute, address generation and result
 */
`default_nettype none

interface vex_ctrl_if;
  import vex_pkg::*;

  fu_kind_t   fu_kind;
  aluop_t     aluop;
  rs1_sel_t   rs1_sel;
  sew_t       sew;
  logic       reduce;
  logic [2:0] eew_bytes;
  ls_mode_t   ls_mode;
  nf_t        nf;
  nf_t        nf_count;
  logic       fullreg;
  logic       legal;

  modport decode (output fu_kind, aluop, rs1_sel, sew, reduce, eew_bytes,
                  ls_mode, nf, nf_count, fullreg, legal);
  modport execute (input fu_kind, aluop, rs1_sel, sew, eew_bytes,
                   ls_mode, nf, nf_count, fullreg, legal);
  modport result (input fu_kind, aluop, sew, reduce, legal);

endinterface

`default_nettype wire

/* vex_pkg.sv */
/*
 * vector execute package
 * widths, field encodings and the two readings of the instruction word
 * shared by decode, execute, address generation and result
 */
`default_nettype none

package vex_pkg;

  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] UNIT_STRIDE_BYTES = 32'd4;

  typedef logic [XLEN-1:0] word_t;

  typedef enum logic [1:0] {
    FU_ALU   = 2'd0,
    FU_LOAD  = 2'd1,
    FU_STORE = 2'd2,
    FU_NONE  = 2'd3
  } fu_kind_t;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_AND  = 3'd1,
    ALU_OR   = 3'd2,
    ALU_XOR  = 3'd3,
    ALU_MIN  = 3'd4,
    ALU_MINU = 3'd5,
    ALU_MAX  = 3'd6,
    ALU_MAXU = 3'd7
  } aluop_t;

  // fourth code of each 2-bit field is reserved
  typedef enum logic [1:0] {RS1_V, RS1_I, RS1_X, RS1_RSVD} rs1_sel_t;
  typedef enum logic [1:0] {SEW8, SEW16, SEW32, SEW_RSVD} sew_t;
  typedef enum logic [1:0] {WIDTH8, WIDTH16, WIDTH32, WIDTH_RSVD} ls_width_t;
  typedef enum logic [1:0] {LS_UNIT, LS_STRIDED, LS_SEGMENT, LS_INDEXED} ls_mode_t;

  typedef logic [2:0] nf_t;

  // fu_kind on top in both views
  typedef struct packed {
    fu_kind_t    fu_kind;
    aluop_t      aluop;
    rs1_sel_t    rs1_sel;
    sew_t        sew;
    logic        reduce;
    logic [21:0] pad;
  } arith_op_t;

  typedef struct packed {
    fu_kind_t    fu_kind;
    ls_width_t   ls_width;
    ls_mode_t    ls_mode;
    nf_t         nf;
    nf_t         nf_count;
    logic        fullreg;
    logic [18:0] pad;
  } mem_op_t;

  typedef union packed {
    arith_op_t arith;
    mem_op_t   mem;
  } op_word_u;

  // signed less-than on the low element bits
  function automatic logic elem_lt(input word_t a, input word_t b, input sew_t sew);
    case (sew)
      SEW8:    return $signed(a[7:0]) < $signed(b[7:0]);
      SEW16:   return $signed(a[15:0]) < $signed(b[15:0]);
      default: return $signed(a) < $signed(b);
    endcase
  endfunction

endpackage

`default_nettype wire
